// File: Makefile
VERILATOR ?= verilator
TOP       := cnn_core_tb
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
src/cnn_pkg.sv
src/line_buffer.sv
src/cnn_kernel.sv
src/cnn_acc_ci.sv
src/cnn_core.sv
dv/cnn_core_properties.sv
dv/cnn_core_tb.sv

// File: dv/cnn_core_properties.sv
`timescale 1ns/1ps

module cnn_core_properties #(
    parameter int CI = 2,
    parameter int CO = 2
) (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     i_acc_vld,
    input logic                     i_ot_valid,
    input cnn_pkg::ciacc_t          i_acc [CO],
    input cnn_pkg::bias_t  [CO-1:0] i_bias,
    input cnn_pkg::ofmap_t [CO-1:0] i_ot_fmap,
    input logic [CI-1:0]            i_win_valid,
    input logic [CI-1:0]            i_lb_state
);

    // ============================================================
    // output valid
    // ============================================================

    a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !i_ot_valid)
        else $error("output valid high during reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (!reset_n)
        i_acc_vld |=> i_ot_valid)
        else $error("accumulator valid not followed by output valid");

    a_valid_source: assert property (@(posedge clk) disable iff (!reset_n)
        i_ot_valid |-> $past(i_acc_vld))
        else $error("output valid without accumulator valid one cycle before");

    // ============================================================
    // relu and line buffer state
    // ============================================================

    for (genvar o = 0; o < CO; o++) begin : gen_relu_chk
        logic signed [cnn_pkg::CIACC_BW:0] sum_c;

        assign sum_c = (cnn_pkg::CIACC_BW+1)'(i_acc[o]) + (cnn_pkg::CIACC_BW+1)'(i_bias[o]);

        a_relu_zero: assert property (@(posedge clk) disable iff (!reset_n)
            (i_acc_vld && sum_c < 0) |=> (i_ot_fmap[o] == '0))
            else $error("negative sum not clamped on channel %0d", o);
    end

    for (genvar c = 0; c < CI; c++) begin : gen_lb_chk
        a_fill_quiet: assert property (@(posedge clk) disable iff (!reset_n)
            i_win_valid[c] |-> (i_lb_state[c] == cnn_pkg::LB_STREAM))
            else $error("window valid from line buffer %0d in fill state", c);
    end

endmodule

// state taps are listed per line buffer for the two-channel build
bind cnn_core cnn_core_properties #(
    .CI (CI),
    .CO (CO)
) u_cnn_core_properties (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_acc_vld   (acc_vld),
    .i_ot_valid  (o_ot_valid),
    .i_acc       (acc),
    .i_bias      (i_cnn_bias),
    .i_ot_fmap   (o_ot_fmap),
    .i_win_valid (win_valid),
    .i_lb_state  ({gen_lb[1].u_line_buffer.state_q, gen_lb[0].u_line_buffer.state_q})
);

// File: dv/cnn_core_tb.sv
`timescale 1ns/1ps

module cnn_core_tb;

    localparam int KX = 3;
    localparam int KY = 3;
    localparam int IX = 6;
    localparam int CI = 2;
    localparam int CO = 2;
    localparam int NW = CO*CI*KX*KY;
    localparam int NPIX = IX*IX;
    localparam int NOUT = (IX-KX+1)*(IX-KY+1);
    localparam int LATENCY = 5;
    localparam int PERIOD = 8;
    localparam int TIMEOUT = 400;

    logic                      clk;
    logic                      reset_n;
    logic                      i_in_valid;
    logic                      i_in_sof;
    cnn_pkg::pixel_t  [CI-1:0] i_in_fmap;
    cnn_pkg::weight_t [NW-1:0] i_cnn_weight;
    cnn_pkg::bias_t   [CO-1:0] i_cnn_bias;
    logic                      o_ot_valid;
    cnn_pkg::ofmap_t  [CO-1:0] o_ot_fmap;

    // stimulus and expected values, two frames
    int pix_data [2][NPIX][CI];
    int exp_data [2][NOUT][CO];

    // captured outputs and their times
    cnn_pkg::ofmap_t [CO-1:0] out_q [$];
    longint                   out_t [$];

    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rng;
    longint      t_window;
    int          fd;

    cnn_core #(
        .KX (KX),
        .KY (KY),
        .IX (IX),
        .CI (CI),
        .CO (CO)
    ) dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_sof     (i_in_sof),
        .i_in_fmap    (i_in_fmap),
        .i_cnn_weight (i_cnn_weight),
        .i_cnn_bias   (i_cnn_bias),
        .o_ot_valid   (o_ot_valid),
        .o_ot_fmap    (o_ot_fmap)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ============================================================
    // output monitor, sampled mid-cycle
    // ============================================================

    always @(negedge clk) begin
        if (o_ot_valid) begin
            out_q.push_back(o_ot_fmap);
            out_t.push_back($time);
        end
    end

    // ============================================================
    // helpers
    // ============================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // outputs captured after t0, up to and including t1
    function automatic int count_outputs_between(input longint t0, input longint t1);
        int n;
        n = 0;
        foreach (out_t[i]) begin
            if (out_t[i] > t0 && out_t[i] <= t1) begin
                n++;
            end
        end
        return n;
    endfunction

    // next number from the file, lines starting with # are skipped
    task automatic read_value(output int v);
        string tok;
        string rest;
        int    code;
        v = 0;
        for (int n = 0; n < 1000; n++) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                errors++;
                $display("stimulus file ended before all values were read");
                return;
            end
            if (tok.getc(0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                if (tok.getc(0) == "-") begin
                    v = -tok.substr(1, tok.len()-1).atoi();
                end else begin
                    v = tok.atoi();
                end
                return;
            end
        end
    endtask

    task automatic load_stimulus();
        int v;
        fd = $fopen("dv/cnn_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file dv/cnn_stimulus.txt");
            return;
        end
        for (int i = 0; i < NW; i++) begin
            read_value(v);
            i_cnn_weight[i] = cnn_pkg::weight_t'(v);
        end
        for (int o = 0; o < CO; o++) begin
            read_value(v);
            i_cnn_bias[o] = cnn_pkg::bias_t'(v);
        end
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < NPIX; i++) begin
                for (int c = 0; c < CI; c++) begin
                    read_value(pix_data[f][i][c]);
                end
            end
            for (int i = 0; i < NOUT; i++) begin
                for (int o = 0; o < CO; o++) begin
                    read_value(exp_data[f][i][o]);
                end
            end
        end
        $fclose(fd);
    endtask

    // raster order, sof on the first pixel, optional random gaps
    task automatic send_frame(input int f, input int npix, input bit gaps);
        int gap;
        for (int i = 0; i < npix; i++) begin
            gap = 0;
            if (gaps) begin
                rng = lcg_next(rng);
                gap = int'(rng[17:16]);
            end
            for (int g = 0; g < gap; g++) begin
                @(negedge clk);
                i_in_valid = 1'b0;
                i_in_sof   = 1'b0;
            end
            @(negedge clk);
            i_in_valid = 1'b1;
            i_in_sof   = (i == 0);
            for (int c = 0; c < CI; c++) begin
                i_in_fmap[c] = cnn_pkg::pixel_t'(pix_data[f][i][c]);
            end
            // first pixel that completes a window
            if (i == (KY-1)*IX + KX-1) begin
                t_window = $time;
            end
        end
        @(negedge clk);
        i_in_valid = 1'b0;
        i_in_sof   = 1'b0;
    endtask

    task automatic clear_capture();
        out_q.delete();
        out_t.delete();
    endtask

    task automatic wait_outputs(input int n, input string what);
        int waited;
        waited = 0;
        while (out_q.size() < n && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (out_q.size() < n) begin
            errors++;
            $display("%s timed out after %0d cycles with %0d of %0d outputs",
                     what, waited, out_q.size(), n);
        end
        // drain, surplus outputs would show up here
        repeat (2*LATENCY) @(negedge clk);
    endtask

    task automatic check_frame(input int f, input string what);
        if (out_q.size() != NOUT) begin
            errors++;
            $display("CHECK FAILED at %0t: %s gave %0d outputs, expected %0d",
                     $time, what, out_q.size(), NOUT);
        end
        for (int i = 0; i < NOUT && i < out_q.size(); i++) begin
            for (int o = 0; o < CO; o++) begin
                if (int'(out_q[i][o]) != exp_data[f][i][o]) begin
                    errors++;
                    $display("CHECK FAILED at %0t: %s output %0d ch %0d is %0d, expected %0d",
                             $time, what, i, o, out_q[i][o], exp_data[f][i][o]);
                end
            end
        end
    endtask

    // only the positions clamped to zero
    task automatic check_relu(input int f);
        int zeros;
        zeros = 0;
        for (int i = 0; i < NOUT && i < out_q.size(); i++) begin
            for (int o = 0; o < CO; o++) begin
                if (exp_data[f][i][o] == 0) begin
                    zeros++;
                    if (out_q[i][o] != '0) begin
                        errors++;
                        $display("CHECK FAILED at %0t: clamped output %0d ch %0d is %0d",
                                 $time, i, o, out_q[i][o]);
                    end
                end
            end
        end
        if (zeros == 0) begin
            errors++;
            $display("no clamped position was captured to check");
        end
    endtask

    task automatic check_latency(input string what);
        int lat;
        if (out_t.size() == 0) begin
            errors++;
            $display("%s produced no output to measure the latency from", what);
        end else begin
            lat = int'((out_t[0] - t_window) / PERIOD);
            if (lat != LATENCY) begin
                errors++;
                $display("CHECK FAILED at %0t: %s latency is %0d cycles, expected %0d",
                         $time, what, lat, LATENCY);
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        int     err0;
        int     n_during;
        int     n_after;
        longint t_reset;
        longint t_release;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        t_window       = 0;
        rng            = 32'h18f3;
        reset_n        = 1'b0;
        i_in_valid     = 1'b0;
        i_in_sof       = 1'b0;
        i_in_fmap      = '0;
        i_cnn_weight   = '0;
        i_cnn_bias     = '0;
        load_stimulus();
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);

        // frame 1 back to back, then relu and latency on the same capture
        err0 = errors;
        clear_capture();
        send_frame(0, NPIX, 1'b0);
        wait_outputs(NOUT, "frame 1");
        check_frame(0, "frame 1");
        finish_test("1 frame back to back", err0);
        err0 = errors;
        check_relu(0);
        finish_test("2 relu clamp", err0);
        err0 = errors;
        check_latency("frame 1");
        finish_test("5 latency", err0);

        // frame 2 with idle gaps
        err0 = errors;
        clear_capture();
        send_frame(1, NPIX, 1'b1);
        wait_outputs(NOUT, "frame 2 with gaps");
        check_frame(1, "frame 2 with gaps");
        finish_test("3 random gaps", err0);

        // partial frame cut short by a new sof
        err0 = errors;
        clear_capture();
        send_frame(0, 10, 1'b0);
        repeat (2*LATENCY) @(negedge clk);
        if (out_q.size() != 0) begin
            errors++;
            $display("CHECK FAILED at %0t: partial frame gave %0d outputs, expected 0",
                     $time, out_q.size());
        end
        clear_capture();
        send_frame(1, NPIX, 1'b0);
        wait_outputs(NOUT, "frame 2 after restart");
        check_frame(1, "frame 2 after restart");
        finish_test("4 frame restart", err0);

        // reset with windows still in flight
        err0 = errors;
        clear_capture();
        send_frame(0, 20, 1'b0);
        // windows of pixels 16 and 17 are still in the pipeline here
        reset_n = 1'b0;
        t_reset = $time;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        t_release = $time;
        repeat (3*LATENCY) @(negedge clk);
        n_during = count_outputs_between(t_reset, t_release);
        n_after  = count_outputs_between(t_release, $time);
        if (n_during != 0 || n_after != 0) begin
            errors++;
            $display("CHECK FAILED at %0t: %0d outputs during and %0d after reset",
                     $time, n_during, n_after);
        end
        clear_capture();
        send_frame(0, NPIX, 1'b0);
        wait_outputs(NOUT, "frame 1 after reset");
        check_frame(0, "frame 1 after reset");
        check_latency("frame 1 after reset");
        finish_test("6 reset mid-stream", err0);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: dv/cnn_stimulus.txt
# weights 9 per line in flat index order, then one bias per output channel
# per frame: 36 pixel pairs (ch0 ch1) in raster order, then 16 expected pairs (o0 o1)
1 1 1 1 1 1 1 1 1
0 0 0 0 2 0 0 0 0
-1 0 0 0 0 0 0 0 1
0 0 0 0 -1 0 0 0 0
-5 -10
# frame 1 pixels
0 0 1 5 2 10 3 4 4 9 5 3
6 3 7 8 8 2 9 7 10 1 11 6
12 6 13 0 14 5 15 10 16 4 17 9
18 9 19 3 20 8 21 2 22 7 23 1
24 1 25 6 26 0 27 5 28 10 29 4
30 4 31 9 32 3 33 8 34 2 35 7
# frame 1 expected
74 0 71 2 90 0 87 3
112 4 131 0 150 0 147 0
172 1 191 0 188 2 207 0
232 0 229 4 248 0 267 0
# frame 2 pixels
200 0 201 5 202 10 203 4 204 9 205 3
206 3 207 8 208 2 209 7 210 1 211 6
212 6 213 0 214 5 215 10 216 4 217 9
218 9 219 3 220 8 221 2 222 7 223 1
224 1 225 6 226 0 227 5 228 10 229 4
230 4 231 9 232 3 233 8 234 2 235 7
# frame 2 expected
1874 0 1871 2 1890 0 1887 3
1912 4 1931 0 1950 0 1947 0
1972 1 1991 0 1988 2 2007 0
2032 0 2029 4 2048 0 2067 0

// File: src/cnn_acc_ci.sv
`timescale 1ns/1ps

module cnn_acc_ci #(
    parameter int KX = 3,
    parameter int KY = 3,
    parameter int CI = 2
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  i_in_valid,
    input  cnn_pkg::pixel_t  [CI*KX*KY-1:0]       i_window,
    input  cnn_pkg::weight_t [CI*KX*KY-1:0]       i_cnn_weight,
    output logic                                  o_ot_valid,
    output cnn_pkg::ciacc_t                       o_ot_ci_acc
);

    // ============================================================
    // one kernel per input channel
    // ============================================================

    cnn_pkg::kernel_result_t kres [CI];
    logic [CI-1:0]           kvalid;

    for (genvar c = 0; c < CI; c++) begin : gen_kernel
        cnn_kernel #(
            .KX (KX),
            .KY (KY)
        ) u_cnn_kernel (
            .clk        (clk),
            .reset_n    (reset_n),
            .i_in_valid (i_in_valid),
            .i_window   (i_window[c*KX*KY +: KX*KY]),
            .i_weight   (i_cnn_weight[c*KX*KY +: KX*KY]),
            .o_result   (kres[c])
        );
        assign kvalid[c] = kres[c].valid;
    end

    // ============================================================
    // cross-channel sum
    // ============================================================

    cnn_pkg::ciacc_t ci_sum;

    always_comb begin
        ci_sum = '0;
        for (int c = 0; c < CI; c++) begin
            // signed cast widens with sign extension
            ci_sum = ci_sum + cnn_pkg::ciacc_t'(kres[c].sum);
        end
    end

    // kernels run in lockstep, so all valids pulse together
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid  <= 1'b0;
            o_ot_ci_acc <= '0;
        end else begin
            o_ot_valid <= &kvalid;
            if (&kvalid) begin
                o_ot_ci_acc <= ci_sum;
            end
        end
    end

endmodule

// File: src/cnn_core.sv
`timescale 1ns/1ps

module cnn_core #(
    parameter int KX = 3,
    parameter int KY = 3,
    parameter int IX = 6,
    parameter int CI = 2,
    parameter int CO = 2
) (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      i_in_valid,
    input  logic                                      i_in_sof,
    input  cnn_pkg::pixel_t  [CI-1:0]                 i_in_fmap,
    input  cnn_pkg::weight_t [CO*CI*KX*KY-1:0]        i_cnn_weight,
    input  cnn_pkg::bias_t   [CO-1:0]                 i_cnn_bias,
    output logic                                      o_ot_valid,
    output cnn_pkg::ofmap_t  [CO-1:0]                 o_ot_fmap
);

    // acc plus bias, one guard bit over the channel sum
    localparam int SUM_BW = cnn_pkg::CIACC_BW + 1;

    // ============================================================
    // line buffers, one per input channel
    // ============================================================

    logic [CI-1:0]                  win_valid;
    cnn_pkg::pixel_t [CI*KX*KY-1:0] win_bus;

    for (genvar c = 0; c < CI; c++) begin : gen_lb
        line_buffer #(
            .KX (KX),
            .KY (KY),
            .IX (IX)
        ) u_line_buffer (
            .clk            (clk),
            .reset_n        (reset_n),
            .i_in_valid     (i_in_valid),
            .i_in_sof       (i_in_sof),
            .i_in_pixel     (i_in_fmap[c]),
            .o_window_valid (win_valid[c]),
            .o_window       (win_bus[c*KX*KY +: KX*KY])
        );
    end

    // ============================================================
    // output channels
    // ============================================================

    logic [CO-1:0]   acc_valid;
    cnn_pkg::ciacc_t acc [CO];
    logic            acc_vld;

    for (genvar o = 0; o < CO; o++) begin : gen_acc
        cnn_acc_ci #(
            .KX (KX),
            .KY (KY),
            .CI (CI)
        ) u_cnn_acc_ci (
            .clk          (clk),
            .reset_n      (reset_n),
            .i_in_valid   (&win_valid),
            .i_window     (win_bus),
            // weights of output channel o, all input channels
            .i_cnn_weight (i_cnn_weight[o*CI*KX*KY +: CI*KX*KY]),
            .o_ot_valid   (acc_valid[o]),
            .o_ot_ci_acc  (acc[o])
        );
    end

    // all channels in lockstep
    assign acc_vld = &acc_valid;

    // ============================================================
    // bias and relu
    // ============================================================

    cnn_pkg::ofmap_t [CO-1:0] fmap_q;

    for (genvar o = 0; o < CO; o++) begin : gen_relu
        logic signed [SUM_BW-1:0] bias_sum;

        // both operands signed, widened before the add
        assign bias_sum = SUM_BW'(acc[o]) + SUM_BW'(i_cnn_bias[o]);

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                fmap_q[o] <= '0;
            end else if (acc_vld) begin
                // negative sums clamp to zero
                fmap_q[o] <= bias_sum[SUM_BW-1] ? '0 : bias_sum[cnn_pkg::OF_BW-1:0];
            end
        end
    end

    // output valid trails the accumulator valid by one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= acc_vld;
        end
    end

    assign o_ot_fmap = fmap_q;

endmodule

// File: src/cnn_kernel.sv
`timescale 1ns/1ps

module cnn_kernel #(
    parameter int KX = 3,
    parameter int KY = 3
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              i_in_valid,
    input  cnn_pkg::pixel_t  [KX*KY-1:0]      i_window,
    input  cnn_pkg::weight_t [KX*KY-1:0]      i_weight,
    output cnn_pkg::kernel_result_t           o_result
);

    // zero-extended pixel times signed weight
    localparam int PROD_BW = cnn_pkg::I_F_BW + 1 + cnn_pkg::W_BW;

    // valid pipe, one bit per stage
    logic [1:0] vld_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_q <= 2'b00;
        end else begin
            vld_q <= {vld_q[0], i_in_valid};
        end
    end

    // ============================================================
    // stage one, products
    // ============================================================

    logic signed [PROD_BW-1:0] prod_q [KX*KY];

    always_ff @(posedge clk) begin
        // free-running, a new window may arrive every cycle
        for (int i = 0; i < KX*KY; i++) begin
            prod_q[i] <= $signed({1'b0, i_window[i]}) * $signed(i_weight[i]);
        end
    end

    // ============================================================
    // stage two, adder tree
    // ============================================================

    cnn_pkg::kacc_t sum_c;
    cnn_pkg::kacc_t sum_q;

    // sign extension of each product into the kernel sum width
    always_comb begin
        sum_c = '0;
        for (int i = 0; i < KX*KY; i++) begin
            sum_c = sum_c + cnn_pkg::kacc_t'(prod_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        sum_q <= sum_c;
    end

    // sum lines up with the second valid bit
    assign o_result = '{valid: vld_q[1], sum: sum_q};

endmodule

// File: src/cnn_pkg.sv
package cnn_pkg;

    // ============================================================
    // data widths
    // ============================================================

    // input pixel, unsigned
    localparam int I_F_BW = 8;

    // weight and bias, both signed
    localparam int W_BW = 8;
    localparam int B_BW = 8;

    // kernel sum, room for a 5x5 window of products
    localparam int KACC_BW = 21;

    // cross-channel sum, room for up to four input channels
    localparam int CIACC_BW = 23;

    // output after relu, unsigned
    localparam int OF_BW = 22;

    // ============================================================
    // scalar types
    // ============================================================

    typedef logic        [I_F_BW-1:0]   pixel_t;
    typedef logic signed [W_BW-1:0]     weight_t;
    typedef logic signed [B_BW-1:0]     bias_t;
    typedef logic signed [KACC_BW-1:0]  kacc_t;
    typedef logic signed [CIACC_BW-1:0] ciacc_t;
    typedef logic        [OF_BW-1:0]    ofmap_t;

    // line buffer state
    // fill: window not complete yet in this frame
    // stream: windows valid wherever the column allows
    typedef enum logic {
        LB_FILL   = 1'b0,
        LB_STREAM = 1'b1
    } lb_state_e;

    // kernel output toward the channel accumulator
    typedef struct packed {
        logic  valid;
        kacc_t sum;
    } kernel_result_t;

endpackage

// File: src/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int KX = 3,
    parameter int KY = 3,
    parameter int IX = 6
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              i_in_valid,
    input  logic                              i_in_sof,
    input  cnn_pkg::pixel_t                   i_in_pixel,
    output logic                              o_window_valid,
    output cnn_pkg::pixel_t [KX*KY-1:0]       o_window
);

    // counter width, at least one bit
    localparam int CW = (IX > 1) ? $clog2(IX) : 1;

    // ============================================================
    // position tracking
    // ============================================================

    // next expected position
    logic [CW-1:0] col_q;
    logic [CW-1:0] row_q;

    // position of the pixel on the bus, sof forces origin
    logic [CW-1:0] cur_col;
    logic [CW-1:0] cur_row;

    cnn_pkg::lb_state_e state_q;
    cnn_pkg::lb_state_e state_nxt;

    assign cur_col = i_in_sof ? '0 : col_q;
    assign cur_row = i_in_sof ? '0 : row_q;

    // origin drops back to fill, first full window enters stream
    always_comb begin
        state_nxt = state_q;
        if (cur_col == '0 && cur_row == '0) begin
            state_nxt = cnn_pkg::LB_FILL;
        end else if (cur_col == CW'(KX-1) && cur_row == CW'(KY-1)) begin
            state_nxt = cnn_pkg::LB_STREAM;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_q          <= '0;
            row_q          <= '0;
            state_q        <= cnn_pkg::LB_FILL;
            o_window_valid <= 1'b0;
        end else begin
            // window is registered along with this strobe
            o_window_valid <= i_in_valid && (state_nxt == cnn_pkg::LB_STREAM)
                              && (cur_col >= CW'(KX-1));
            if (i_in_valid) begin
                state_q <= state_nxt;
                // column wraps at end of row, row wraps at end of map
                if (cur_col == CW'(IX-1)) begin
                    col_q <= '0;
                    row_q <= (cur_row == CW'(IX-1)) ? '0 : cur_row + 1'b1;
                end else begin
                    col_q <= cur_col + 1'b1;
                    row_q <= cur_row;
                end
            end
        end
    end

    // ============================================================
    // row storage and window
    // ============================================================

    // row_mem[0] holds the previous row, row_mem[1] the one before
    cnn_pkg::pixel_t row_mem [0:KY-2][0:IX-1];

    // one column of the window, top row first
    cnn_pkg::pixel_t [KY-1:0] col_vec;

    cnn_pkg::pixel_t [KX*KY-1:0] win_q;

    always_comb begin
        col_vec[KY-1] = i_in_pixel;
        for (int r = 0; r < KY-1; r++) begin
            col_vec[r] = row_mem[KY-2-r][cur_col];
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            // push the column down through the row memories
            row_mem[0][cur_col] <= i_in_pixel;
            for (int j = 1; j < KY-1; j++) begin
                row_mem[j][cur_col] <= row_mem[j-1][cur_col];
            end
            // shift window left, new column enters at k = KX-1
            for (int r = 0; r < KY; r++) begin
                for (int k = 0; k < KX-1; k++) begin
                    win_q[r*KX+k] <= win_q[r*KX+k+1];
                end
                win_q[r*KX+KX-1] <= col_vec[r];
            end
        end
    end

    assign o_window = win_q;

endmodule
